//--- cache_pkg.sv
// Shared widths and address layout for the cache
// One data word per line so an address holds only tag and index
// Way count is a module parameter and defaults to default_ways
`default_nettype none

package cache_pkg;

    // ====================
    // Widths
    // ====================
    localparam int addr_w  = 16;
    localparam int data_w  = 32;
    // 16 sets
    localparam int index_w = 4;
    localparam int tag_w   = addr_w - index_w;

    // Default associativity for the top level
    localparam int default_ways = 4;

    // ====================
    // Address views
    // ====================
    // Raw word for the memory port
    // Tag above index for the arrays
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
        } fields;
    } cache_addr_t;

    // One history bit per way pair
    function automatic int use_history_w(input int n_ways);
        return (n_ways * (n_ways - 1)) / 2;
    endfunction

endpackage

`default_nettype wire

//--- lru_update.sv
// Matrix true LRU for one set
// History bit set when the lower-numbered way of a pair is the older one
// All-zero history makes the highest way the LRU way
// Needs ways of 2 or more
`timescale 1ns/1ps
`default_nettype none

module lru_update #(
    parameter int ways = cache_pkg::default_ways
) (
    input  logic [cache_pkg::use_history_w(ways)-1:0] use_history,
    input  logic [ways-1:0]                           access,
    output logic [cache_pkg::use_history_w(ways)-1:0] next_use_history,
    output logic [ways-1:0]                           next_lru
);

    // Bit [i][j] set when way i is older than way j
    logic [ways-1:0] order [ways];

    always_comb begin
        int base;

        // ====================
        // Expand history
        // ====================
        base = 0;
        for (int i = 0; i < ways; i++) begin
            // Diagonal counts as older so a full row marks the LRU way
            order[i][i] = 1'b1;
            for (int j = i + 1; j < ways; j++) begin
                order[i][j] = use_history[base + j - i - 1];
            end
            base = base + ways - i - 1;
        end
        // Lower triangle mirrors the upper one
        for (int i = 1; i < ways; i++) begin
            for (int j = 0; j < i; j++) begin
                order[i][j] = ~order[j][i];
            end
        end

        // ====================
        // Apply access
        // ====================
        for (int i = 0; i < ways; i++) begin
            if (access[i]) begin
                for (int j = 0; j < ways; j++) begin
                    if (j != i) begin
                        // Accessed way becomes newer than every other
                        order[i][j] = 1'b0;
                        order[j][i] = 1'b1;
                    end
                end
            end
        end

        // Repack upper triangle
        base = 0;
        for (int i = 0; i < ways; i++) begin
            for (int j = i + 1; j < ways; j++) begin
                next_use_history[base + j - i - 1] = order[i][j];
            end
            base = base + ways - i - 1;
        end

        // Oldest way has an all-ones row
        for (int i = 0; i < ways; i++) begin
            next_lru[i] = &order[i];
        end
    end

endmodule

`default_nettype wire

//--- lru_state_array.sv
// Per-set LRU history storage
// lru_way shows the history after the gated access of this cycle
// Reset zeroes every history
`timescale 1ns/1ps
`default_nettype none

module lru_state_array #(
    parameter int ways = cache_pkg::default_ways
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic                          touch,
    input  logic [ways-1:0]               touch_way,
    output logic [ways-1:0]               lru_way
);

    import cache_pkg::*;

    localparam int sets   = 1 << index_w;
    localparam int hist_w = use_history_w(ways);

    logic [hist_w-1:0] hist_q [sets];
    logic [hist_w-1:0] hist_next;
    // No access unless the controller strobes touch
    logic [ways-1:0]   access;

    assign access = {ways{touch}} & touch_way;

    lru_update #(
        .ways(ways)
    ) u_lru_update (
        .use_history      (hist_q[index]),
        .access           (access),
        .next_use_history (hist_next),
        .next_lru         (lru_way)
    );

    // Write back only the addressed set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < sets; s++) begin
                hist_q[s] <= '0;
            end
        end else if (touch) begin
            hist_q[index] <= hist_next;
        end
    end

endmodule

`default_nettype wire

//--- tag_array.sv
// Valid and tag storage for every way and set
// Hit compare and free-way search are combinational on the current set
// Reset clears valid bits only
`timescale 1ns/1ps
`default_nettype none

module tag_array #(
    parameter int ways = cache_pkg::default_ways
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic [cache_pkg::tag_w-1:0]   tag,
    input  logic                          fill,
    input  logic [ways-1:0]               fill_way,
    output logic [ways-1:0]               hit_way,
    output logic [ways-1:0]               free_way
);

    import cache_pkg::*;

    localparam int sets = 1 << index_w;

    logic [sets-1:0]  valid_q [ways];
    logic [tag_w-1:0] tag_q   [ways][sets];

    // ====================
    // Lookup
    // ====================
    always_comb begin
        logic found;

        found = 1'b0;
        for (int w = 0; w < ways; w++) begin
            hit_way[w]  = valid_q[w][index] && (tag_q[w][index] == tag);
            // Lowest invalid way wins
            free_way[w] = !valid_q[w][index] && !found;
            found       = found || !valid_q[w][index];
        end
    end

    // ====================
    // Fill
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < ways; w++) begin
                valid_q[w] <= '0;
            end
        end else if (fill) begin
            for (int w = 0; w < ways; w++) begin
                if (fill_way[w]) begin
                    valid_q[w][index] <= 1'b1;
                end
            end
        end
    end

    // Tags follow the valid bit write
    always_ff @(posedge clk) begin
        if (fill) begin
            for (int w = 0; w < ways; w++) begin
                if (fill_way[w]) begin
                    tag_q[w][index] <= tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- data_array.sv
// One data word per way and set
// Read is combinational and OR-selected by a one-hot way vector
// Zero read way gives zero data
`timescale 1ns/1ps
`default_nettype none

module data_array #(
    parameter int ways = cache_pkg::default_ways
) (
    input  logic                          clk,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic                          wen,
    input  logic [ways-1:0]               wway,
    input  logic [cache_pkg::data_w-1:0]  wdata,
    input  logic [ways-1:0]               rway,
    output logic [cache_pkg::data_w-1:0]  rdata
);

    import cache_pkg::*;

    localparam int sets = 1 << index_w;

    logic [data_w-1:0] mem_q [ways][sets];

    // Write selected way of the current set
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int w = 0; w < ways; w++) begin
                if (wway[w]) begin
                    mem_q[w][index] <= wdata;
                end
            end
        end
    end

    // AND-OR read mux
    always_comb begin
        rdata = '0;
        for (int w = 0; w < ways; w++) begin
            if (rway[w]) begin
                rdata = rdata | mem_q[w][index];
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_ctrl.sv
// Blocking cache controller with one request in flight
// Reads allocate on a miss and writes go through without allocating
// mem_wdata carries mem_rdata during reads as the fill data path
// Read hits finish in the lookup cycle and all else waits for mem_ack
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int ways = cache_pkg::default_ways
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          we,
    input  cache_pkg::cache_addr_t        addr,
    input  logic [cache_pkg::data_w-1:0]  wdata,
    output logic                          busy,
    output logic                          done,
    output logic                          hit,
    output logic [cache_pkg::data_w-1:0]  rdata,
    output logic                          mem_rd,
    output logic                          mem_wr,
    output logic [cache_pkg::addr_w-1:0]  mem_addr,
    output logic [cache_pkg::data_w-1:0]  mem_wdata,
    input  logic                          mem_ack,
    input  logic [cache_pkg::data_w-1:0]  mem_rdata,
    output logic [cache_pkg::index_w-1:0] index,
    output logic [cache_pkg::tag_w-1:0]   tag,
    input  logic [ways-1:0]               hit_way,
    input  logic [ways-1:0]               free_way,
    input  logic [ways-1:0]               lru_way,
    output logic                          fill,
    output logic [ways-1:0]               fill_way,
    output logic                          data_wen,
    output logic [ways-1:0]               data_way,
    output logic                          touch,
    output logic [ways-1:0]               touch_way,
    input  logic [cache_pkg::data_w-1:0]  array_rdata
);

    import cache_pkg::*;

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_lookup = 2'd1;
    localparam logic [1:0] st_mem    = 2'd2;
    localparam logic [1:0] st_done   = 2'd3;

    logic [1:0]        state_q;
    logic [1:0]        state_next;
    // Captured request
    cache_addr_t       addr_q;
    logic              we_q;
    logic [data_w-1:0] wdata_q;
    // Lookup outcome kept for the memory phase
    logic              hit_q;
    logic [ways-1:0]   way_q;
    logic              in_lookup;
    logic              lookup_hit;
    logic              read_hit;
    logic              ack_now;
    logic [ways-1:0]   victim;

    assign in_lookup  = (state_q == st_lookup);
    assign lookup_hit = |hit_way;
    assign read_hit   = in_lookup && lookup_hit && !we_q;
    assign ack_now    = (state_q == st_mem) && mem_ack;
    // Free way first and LRU way when the set is full
    assign victim     = (free_way != '0) ? free_way : lru_way;

    // ====================
    // FSM
    // ====================
    always_comb begin
        state_next = state_q;
        case (state_q)
            st_idle:   if (req) state_next = st_lookup;
            st_lookup: state_next = read_hit ? st_idle : st_mem;
            st_mem:    if (mem_ack) state_next = st_done;
            st_done:   state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_next;
        end
    end

    // Request only taken while idle
    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && req) begin
            addr_q  <= addr;
            we_q    <= we;
            wdata_q <= wdata;
        end
        if (in_lookup) begin
            hit_q <= lookup_hit;
            // Writes update only the hit way
            way_q <= we_q ? hit_way : victim;
        end
    end

    // ====================
    // Outputs
    // ====================
    assign busy  = (state_q != st_idle);
    assign done  = read_hit || (state_q == st_done);
    assign hit   = in_lookup ? lookup_hit : hit_q;
    // After a fill the array already holds mem_rdata
    assign rdata = array_rdata;

    // Pulses in the lookup cycle
    assign mem_rd    = in_lookup && !we_q && !lookup_hit;
    assign mem_wr    = in_lookup && we_q;
    // Held by addr_q until the ack
    assign mem_addr  = addr_q.raw;
    assign mem_wdata = we_q ? wdata_q : mem_rdata;

    assign index = addr_q.fields.index;
    assign tag   = addr_q.fields.tag;

    // Array updates on the ack edge
    assign fill      = ack_now && !we_q;
    assign fill_way  = way_q;
    assign data_wen  = ack_now && (!we_q || hit_q);
    assign data_way  = in_lookup ? hit_way : way_q;
    assign touch     = read_hit || data_wen;
    assign touch_way = data_way;

endmodule

`default_nettype wire

//--- set_assoc_cache.sv
// Set-associative cache top level with write-through and read allocate
// Requester and memory ports are plain strobes and levels
// ways must be 2 or more
`timescale 1ns/1ps
`default_nettype none

module set_assoc_cache #(
    parameter int ways = cache_pkg::default_ways
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  logic                         we,
    input  logic [cache_pkg::addr_w-1:0] addr,
    input  logic [cache_pkg::data_w-1:0] wdata,
    output logic                         busy,
    output logic                         done,
    output logic                         hit,
    output logic [cache_pkg::data_w-1:0] rdata,
    output logic                         mem_rd,
    output logic                         mem_wr,
    output logic [cache_pkg::addr_w-1:0] mem_addr,
    output logic [cache_pkg::data_w-1:0] mem_wdata,
    input  logic                         mem_ack,
    input  logic [cache_pkg::data_w-1:0] mem_rdata
);

    import cache_pkg::*;

    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic [ways-1:0]    hit_way;
    logic [ways-1:0]    free_way;
    logic [ways-1:0]    lru_way;
    logic               fill;
    logic [ways-1:0]    fill_way;
    logic               data_wen;
    logic [ways-1:0]    data_way;
    logic               touch;
    logic [ways-1:0]    touch_way;
    logic [data_w-1:0]  array_rdata;

    // ====================
    // Control
    // ====================
    cache_ctrl #(
        .ways(ways)
    ) u_cache_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .done        (done),
        .hit         (hit),
        .rdata       (rdata),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .index       (index),
        .tag         (tag),
        .hit_way     (hit_way),
        .free_way    (free_way),
        .lru_way     (lru_way),
        .fill        (fill),
        .fill_way    (fill_way),
        .data_wen    (data_wen),
        .data_way    (data_way),
        .touch       (touch),
        .touch_way   (touch_way),
        .array_rdata (array_rdata)
    );

    // ====================
    // Arrays
    // ====================
    tag_array #(
        .ways(ways)
    ) u_tag_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .tag      (tag),
        .fill     (fill),
        .fill_way (fill_way),
        .hit_way  (hit_way),
        .free_way (free_way)
    );

    // Write data shares the memory write bus
    data_array #(
        .ways(ways)
    ) u_data_array (
        .clk   (clk),
        .index (index),
        .wen   (data_wen),
        .wway  (data_way),
        .wdata (mem_wdata),
        .rway  (data_way),
        .rdata (array_rdata)
    );

    lru_state_array #(
        .ways(ways)
    ) u_lru_state_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .touch     (touch),
        .touch_way (touch_way),
        .lru_way   (lru_way)
    );

endmodule

`default_nettype wire

//--- set_assoc_cache_properties.sv
// Protocol checks on the controller strobes
// Bound to every cache_ctrl instance and quiet during reset
`timescale 1ns/1ps
`default_nettype none

module set_assoc_cache_properties (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic mem_rd,
    input logic mem_wr,
    input logic mem_ack
);

    // Memory access issued and not yet acknowledged
    logic outstanding;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (mem_rd || mem_wr) begin
            outstanding <= 1'b1;
        end else if (mem_ack) begin
            outstanding <= 1'b0;
        end
    end

    // ====================
    // Properties
    // ====================
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr high in the same cycle");

    // One memory access at a time
    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !(mem_rd || mem_wr))
        else $error("memory pulse issued before the previous ack");

endmodule

bind cache_ctrl set_assoc_cache_properties u_properties (
    .clk     (clk),
    .rst_n   (rst_n),
    .done    (done),
    .mem_rd  (mem_rd),
    .mem_wr  (mem_wr),
    .mem_ack (mem_ack)
);

`default_nettype wire

//--- tb_set_assoc_cache.sv
// Directed testbench for the cache with a random-latency memory model
// Assumes the default 4 ways
// Memory words are a fixed address pattern unless written
`timescale 1ns/1ps
`default_nettype none

module tb_set_assoc_cache;

    import cache_pkg::*;

    // Upper bound on requests issued by all tests
    localparam int n_requests     = 44;
    localparam int timeout_cycles = n_requests * 8 + 100;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              busy;
    logic              done;
    logic              hit;
    logic [data_w-1:0] rdata;
    logic              mem_rd;
    logic              mem_wr;
    logic [addr_w-1:0] mem_addr;
    logic [data_w-1:0] mem_wdata;
    logic              mem_ack = 1'b0;
    logic [data_w-1:0] mem_rdata = '0;

    // Memory model state
    logic [data_w-1:0] written_words [logic [addr_w-1:0]];
    int                wait_cnt = 0;
    int                rd_count = 0;
    int                wr_count = 0;
    int                cycle_count = 0;
    logic [addr_w-1:0] pend_addr = '0;
    logic              pend_wr = 1'b0;
    logic [data_w-1:0] last_wdata = '0;

    set_assoc_cache #(
        .ways(default_ways)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .done      (done),
        .hit       (hit),
        .rdata     (rdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    always #50 clk = ~clk;

    // ====================
    // Helpers
    // ====================
    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Tag above index
    function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] t,
                                                    input logic [index_w-1:0] i);
        return {t, i};
    endfunction

    // Unwritten memory content, spread over all address bits
    function automatic logic [data_w-1:0] backing_value(input logic [addr_w-1:0] a);
        return {a ^ 16'h5ac3, a + 16'h1f07};
    endfunction

    function automatic logic [data_w-1:0] memory_word(input logic [addr_w-1:0] a);
        if (written_words.exists(a)) begin
            return written_words[a];
        end
        return backing_value(a);
    endfunction

    // ====================
    // Memory model
    // ====================
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (!rst_n) begin
            wait_cnt <= 0;
        end else if (wait_cnt != 0) begin
            // Address and write data must hold until the ack
            check_value("mem_addr", 32'(mem_addr), 32'(pend_addr));
            if (pend_wr) begin
                check_value("mem_wdata", mem_wdata, last_wdata);
            end
            assert (!(mem_rd || mem_wr)) else begin
                $display("Memory pulse issued while a previous access waits for ack");
                abort_run();
            end
            if (wait_cnt == 1) begin
                mem_ack   <= 1'b1;
                mem_rdata <= memory_word(pend_addr);
            end
            wait_cnt <= wait_cnt - 1;
        end else if (mem_rd || mem_wr) begin
            assert (!(mem_rd && mem_wr)) else begin
                $display("mem_rd and mem_wr pulsed in the same cycle");
                abort_run();
            end
            pend_addr <= mem_addr;
            pend_wr   <= mem_wr;
            wait_cnt  <= 1 + int'($urandom % 4);
            if (mem_rd) begin
                rd_count <= rd_count + 1;
            end else begin
                written_words[mem_addr] = mem_wdata;
                last_wdata <= mem_wdata;
                wr_count   <= wr_count + 1;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    // ====================
    // Request tasks
    // ====================
    // Latency counts cycles from req to done
    // ack_lat is the latency at which mem_ack was seen, zero if never
    task automatic issue_request(input logic wr, input logic [addr_w-1:0] a,
                                 input logic [data_w-1:0] d, output int lat,
                                 output int ack_lat, output logic lookup_rd,
                                 output logic lookup_wr,
                                 output logic got_hit, output logic [data_w-1:0] got_rdata);
        @(posedge clk);
        req   <= 1'b1;
        we    <= wr;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        req <= 1'b0;
        lat     = 1;
        ack_lat = 0;
        @(negedge clk);
        // Memory strobes belong to the lookup cycle
        lookup_rd = mem_rd;
        lookup_wr = mem_wr;
        while (!done) begin
            if (mem_ack) begin
                ack_lat = lat;
            end
            @(negedge clk);
            lat++;
        end
        check_value("busy", 32'(busy), 32'd1);
        got_hit   = hit;
        got_rdata = rdata;
        // Back to idle one cycle after done
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic read_check(input logic [addr_w-1:0] a, input logic exp_hit,
                              input logic [data_w-1:0] exp_data);
        int                rd_before;
        int                wr_before;
        int                lat;
        int                ack_lat;
        logic              lookup_rd;
        logic              lookup_wr;
        logic              got_hit;
        logic [data_w-1:0] got_rdata;

        rd_before = rd_count;
        wr_before = wr_count;
        issue_request(1'b0, a, '0, lat, ack_lat, lookup_rd, lookup_wr, got_hit, got_rdata);
        check_value("hit", 32'(got_hit), 32'(exp_hit));
        check_value("rdata", got_rdata, exp_data);
        check_value("mem_rd in lookup", 32'(lookup_rd), exp_hit ? 32'd0 : 32'd1);
        check_value("mem_wr in lookup", 32'(lookup_wr), 32'd0);
        check_value("mem_rd pulses", rd_count - rd_before, exp_hit ? 0 : 1);
        check_value("mem_wr pulses", wr_count - wr_before, 0);
        if (exp_hit) begin
            check_value("read hit latency", lat, 1);
        end else begin
            check_value("mem_addr", 32'(pend_addr), 32'(a));
            check_value("done after mem_ack", lat - ack_lat, 1);
        end
    endtask

    // Write through, no allocate
    task automatic write_check(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                               input logic exp_hit);
        int                rd_before;
        int                wr_before;
        int                lat;
        int                ack_lat;
        logic              lookup_rd;
        logic              lookup_wr;
        logic              got_hit;
        logic [data_w-1:0] got_rdata;

        rd_before = rd_count;
        wr_before = wr_count;
        issue_request(1'b1, a, d, lat, ack_lat, lookup_rd, lookup_wr, got_hit, got_rdata);
        check_value("hit", 32'(got_hit), 32'(exp_hit));
        check_value("mem_wr in lookup", 32'(lookup_wr), 32'd1);
        check_value("mem_rd in lookup", 32'(lookup_rd), 32'd0);
        check_value("mem_wr pulses", wr_count - wr_before, 1);
        check_value("mem_rd pulses", rd_count - rd_before, 0);
        check_value("mem_addr", 32'(pend_addr), 32'(a));
        check_value("mem_wdata", last_wdata, d);
        check_value("done after mem_ack", lat - ack_lat, 1);
    endtask

    // Strobes and busy low once reset is released
    task automatic expect_idle_after_reset();
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("mem_rd", 32'(mem_rd), 32'd0);
        check_value("mem_wr", 32'(mem_wr), 32'd0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        expect_idle_after_reset();
    endtask

    // ====================
    // Tests
    // ====================
    task automatic test_read_miss_then_hit();
        logic [addr_w-1:0] a;

        a = make_addr(12'h123, 4'h2);
        read_check(a, 1'b0, backing_value(a));
        read_check(a, 1'b1, backing_value(a));
    endtask

    // Fill set 3, age the fourth way, then replace it
    task automatic test_lru_replacement();
        logic [addr_w-1:0] a [5];

        for (int i = 0; i < 5; i++) begin
            a[i] = make_addr(12'h200 + 12'(i), 4'h3);
        end
        for (int i = 0; i < 4; i++) begin
            read_check(a[i], 1'b0, backing_value(a[i]));
        end
        for (int i = 0; i < 3; i++) begin
            read_check(a[i], 1'b1, backing_value(a[i]));
        end
        read_check(a[4], 1'b0, backing_value(a[4]));
        for (int i = 0; i < 3; i++) begin
            read_check(a[i], 1'b1, backing_value(a[i]));
        end
        // Evicted line
        read_check(a[3], 1'b0, backing_value(a[3]));
    endtask

    task automatic test_write_hit();
        logic [addr_w-1:0] a;

        a = make_addr(12'h3a0, 4'h9);
        read_check(a, 1'b0, backing_value(a));
        write_check(a, 32'hdead_beef, 1'b1);
        read_check(a, 1'b1, 32'hdead_beef);
    endtask

    task automatic test_write_miss();
        logic [addr_w-1:0] a;

        a = make_addr(12'h4b1, 4'ha);
        write_check(a, 32'h1357_9bdf, 1'b0);
        read_check(a, 1'b0, 32'h1357_9bdf);
    endtask

    // Set 8 traffic must not age set 7
    task automatic test_set_isolation();
        logic [addr_w-1:0] s7 [5];
        logic [addr_w-1:0] s8_a;
        logic [addr_w-1:0] s8_b;

        for (int i = 0; i < 5; i++) begin
            s7[i] = make_addr(12'h600 + 12'(i), 4'h7);
        end
        s8_a = make_addr(12'h603, 4'h8);
        s8_b = make_addr(12'h600, 4'h8);
        for (int i = 0; i < 4; i++) begin
            read_check(s7[i], 1'b0, backing_value(s7[i]));
        end
        for (int i = 0; i < 3; i++) begin
            read_check(s7[i], 1'b1, backing_value(s7[i]));
        end
        read_check(s8_a, 1'b0, backing_value(s8_a));
        read_check(s8_a, 1'b1, backing_value(s8_a));
        read_check(s8_b, 1'b0, backing_value(s8_b));
        read_check(s8_b, 1'b1, backing_value(s8_b));
        read_check(s7[4], 1'b0, backing_value(s7[4]));
        for (int i = 0; i < 3; i++) begin
            read_check(s7[i], 1'b1, backing_value(s7[i]));
        end
        read_check(s8_a, 1'b1, backing_value(s8_a));
        read_check(s8_b, 1'b1, backing_value(s8_b));
    endtask

    task automatic test_reset_invalidates();
        logic [addr_w-1:0] a1;
        logic [addr_w-1:0] a2;

        a1 = make_addr(12'h123, 4'h2);
        a2 = make_addr(12'h3a0, 4'h9);
        read_check(a1, 1'b1, backing_value(a1));
        read_check(a2, 1'b1, 32'hdead_beef);
        apply_reset();
        // Memory keeps its written words
        read_check(a1, 1'b0, backing_value(a1));
        read_check(a2, 1'b0, 32'hdead_beef);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'h83d4_91b3));
        rst_n = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        expect_idle_after_reset();

        test_read_miss_then_hit();
        test_lru_replacement();
        test_write_hit();
        test_write_miss();
        test_set_isolation();
        test_reset_invalidates();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- set_assoc_cache.f
cache_pkg.sv
lru_update.sv
lru_state_array.sv
tag_array.sv
data_array.sv
cache_ctrl.sv
set_assoc_cache.sv
set_assoc_cache_properties.sv
tb_set_assoc_cache.sv

//--- Makefile
# Verilator build and run of the cache testbench

TOP := tb_set_assoc_cache
RTL := cache_pkg.sv lru_update.sv lru_state_array.sv tag_array.sv \
       data_array.sv cache_ctrl.sv set_assoc_cache.sv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f set_assoc_cache.f --top-module $(TOP)
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	grep -q "=== PASS ===" run.log

lint:
	verilator --lint-only -Wall --top-module set_assoc_cache $(RTL)

clean:
	rm -rf obj_dir run.log
